// File: build.f
common/switch_pkg.sv
source/flow_fifo.sv
control/link_fsm.sv
source/vc_router.sv
source/dest_arbiter.sv
source/switch_top.sv
tests/clock_gen.sv
tests/switch_props.sv
tests/switch_tb.sv

// File: Makefile
SRCS := $(wildcard common/*.sv control/*.sv source/*.sv tests/*.sv)

.PHONY: run clean

run: obj_dir/Vswitch_tb
	./obj_dir/Vswitch_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log

# rebuilt only when a source or the file list changes
obj_dir/Vswitch_tb: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module switch_tb \
		-Mdir obj_dir -o Vswitch_tb

clean:
	rm -rf obj_dir sim.log

// File: tests/switch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module switch_tb;

    localparam int WAIT_LIMIT = 100;
    localparam int DRAIN_LIMIT = 600;
    localparam int W_RESET = 0;
    localparam int W_THRESH = 1;
    localparam int W_IDLE = 2;
    localparam int W_ACTIVE = 3;
    localparam int W_ERROR = 4;
    // main thresholds loaded during init
    localparam int NEW_MF_AF = 3;
    localparam int NEW_MF_AE = 1;

    logic                             clk;
    logic                             reset_L;
    logic                             init;
    switch_pkg::thresh_t              thresh_in;
    logic                             push;
    switch_pkg::flit_t                push_data;
    logic [1:0]                       pop;
    switch_pkg::flit_t [1:0]          dest_data;
    logic [1:0]                       dest_empty;
    logic [switch_pkg::NUM_FIFOS-1:0] error_vec;
    logic                             idle;
    logic                             active;
    switch_pkg::thresh_t              thresh_out;
    logic                             main_af;
    logic                             main_ae;

    switch_pkg::thresh_t default_thresh;
    switch_pkg::thresh_t new_thresh;
    switch_pkg::flit_t   exp_q [2][$];
    string               test_name;
    int                  mismatch_count;
    int                  fail_count;

    clock_gen i_clock_gen (
        .clk_o     (clk),
        .reset_L_o (reset_L)
    );

    switch_top i_switch_top (
        .clk          (clk),
        .reset_L      (reset_L),
        .init_i       (init),
        .thresh_i     (thresh_in),
        .push_i       (push),
        .push_data_i  (push_data),
        .pop_i        (pop),
        .dest_data_o  (dest_data),
        .dest_empty_o (dest_empty),
        .error_o      (error_vec),
        .idle_o       (idle),
        .active_o     (active),
        .thresh_o     (thresh_out),
        .main_af_o    (main_af),
        .main_ae_o    (main_ae)
    );

    function automatic switch_pkg::thresh_t make_thresh(input int mf_af, input int mf_ae,
                                                        input int vc_af, input int vc_ae,
                                                        input int d_af, input int d_ae);
        switch_pkg::thresh_t t;
        t.mf_af = 2'(mf_af);
        t.mf_ae = 2'(mf_ae);
        t.vc_af = 4'(vc_af);
        t.vc_ae = 4'(vc_ae);
        t.d_af = 2'(d_af);
        t.d_ae = 2'(d_ae);
        return t;
    endfunction

    function automatic logic condition_met(input int which);
        case (which)
            W_RESET:  return reset_L;
            W_THRESH: return thresh_out == new_thresh;
            W_IDLE:   return idle;
            W_ACTIVE: return active;
            W_ERROR:  return error_vec != '0;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else begin
            $display("MISMATCH %s %s: expected %0h actual %0h",
                     test_name, what, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic wait_until(input int which, input string what);
        int n;
        n = 0;
        while (condition_met(which) !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (condition_met(which) !== 1'b1) begin
            $display("timeout in %s: %s did not happen within %0d cycles",
                     test_name, what, WAIT_LIMIT);
            fail_count++;
        end
    endtask

    // oldest word queued for this destination on the same channel
    task automatic check_popped(input int d);
        switch_pkg::flit_t got;
        switch_pkg::flit_t cand;
        int idx;
        int i;
        got = dest_data[d];
        idx = -1;
        for (i = 0; i < exp_q[d].size(); i++) begin
            cand = exp_q[d][i];
            if (idx < 0 && cand.vc == got.vc) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("%s: destination %0d delivered word %0h that was never sent there",
                     test_name, d, got);
            fail_count++;
        end else begin
            check_value("dest word", {26'b0, exp_q[d][idx]}, {26'b0, got});
            exp_q[d].delete(idx);
        end
    endtask

    task automatic cycle_step(input logic want_push, input logic popping,
                              output logic pushed);
        switch_pkg::flit_t word;
        int d;
        for (d = 0; d < 2; d++) begin
            if (popping && !dest_empty[d]) begin
                check_popped(d);
                pop[d] = 1'b1;
            end else begin
                pop[d] = 1'b0;
            end
        end
        pushed = want_push && !main_af;
        push = pushed;
        if (pushed) begin
            word = 6'($urandom);
            push_data = word;
            exp_q[word.dest].push_back(word);
        end
    endtask

    task automatic drain_destinations();
        int n;
        logic pushed;
        n = 0;
        while (exp_q[0].size() + exp_q[1].size() > 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            cycle_step(1'b0, 1'b1, pushed);
            n++;
        end
        @(negedge clk);
        pop = 2'b00;
        push = 1'b0;
        if (exp_q[0].size() + exp_q[1].size() > 0) begin
            $display("timeout in %s: %0d words never reached their destination",
                     test_name, exp_q[0].size() + exp_q[1].size());
            fail_count++;
        end
    endtask

    initial begin
        logic pushed;
        int sent;
        int stall;
        int n;
        int k;
        void'($urandom(35661));
        mismatch_count = 0;
        fail_count = 0;
        default_thresh = make_thresh(2, 2, 10, 3, 2, 2);
        new_thresh = make_thresh(NEW_MF_AF, NEW_MF_AE, 12, 4, 3, 1);
        init = 1'b0;
        thresh_in = default_thresh;
        push = 1'b0;
        push_data = '0;
        pop = 2'b00;

        test_name = "reset";
        wait_until(W_RESET, "reset release");
        check_value("thresholds", {16'b0, default_thresh}, {16'b0, thresh_out});
        check_value("idle", 0, 32'(idle));
        check_value("active", 0, 32'(active));
        check_value("error", 0, 32'(error_vec));

        test_name = "init";
        init = 1'b1;
        thresh_in = new_thresh;
        wait_until(W_THRESH, "threshold load");
        check_value("idle", 0, 32'(idle));
        init = 1'b0;
        wait_until(W_IDLE, "idle after init");
        check_value("thresholds", {16'b0, new_thresh}, {16'b0, thresh_out});
        check_value("dest empty", 3, 32'(dest_empty));

        test_name = "traffic";
        sent = 0;
        n = 0;
        while (sent < 4 && n < WAIT_LIMIT) begin
            @(negedge clk);
            cycle_step(1'b1, 1'b0, pushed);
            if (pushed) begin
                sent++;
            end
            n++;
        end
        @(negedge clk);
        push = 1'b0;
        wait_until(W_ACTIVE, "active after pushes");
        sent = 0;
        n = 0;
        while (sent < 40 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            cycle_step(1'b1, 1'b1, pushed);
            if (pushed) begin
                sent++;
            end
            n++;
        end
        drain_destinations();
        wait_until(W_IDLE, "idle after traffic");

        // no pops, so the whole path backs up into the main FIFO
        test_name = "backpressure";
        stall = 0;
        n = 0;
        while (stall < 12 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            cycle_step(1'b1, 1'b0, pushed);
            stall = pushed ? 0 : stall + 1;
            n++;
        end
        if (stall < 12) begin
            $display("%s: main FIFO never stayed almost full", test_name);
            fail_count++;
        end
        check_value("main almost full", 1, 32'(main_af));
        check_value("main almost empty", 0, 32'(main_ae));
        check_value("dest empty", 0, 32'(dest_empty));
        drain_destinations();
        wait_until(W_IDLE, "idle after backpressure");
        check_value("main almost full", 0, 32'(main_af));
        check_value("main almost empty", 1, 32'(main_ae));
        check_value("dest empty", 3, 32'(dest_empty));

        test_name = "error";
        check_value("d1 empty", 1, 32'(dest_empty[1]));
        pop = 2'b10;
        @(negedge clk);
        pop = 2'b00;
        wait_until(W_ERROR, "error capture");
        check_value("error vector", 16, 32'(error_vec));
        check_value("idle", 0, 32'(idle));
        check_value("active", 0, 32'(active));
        // frozen router, so main occupancy equals the push count
        for (k = 1; k <= 3; k++) begin
            @(negedge clk);
            push_data = 6'($urandom);
            push = 1'b1;
            @(negedge clk);
            push = 1'b0;
            check_value("main almost empty", 32'(k <= NEW_MF_AE), 32'(main_ae));
            check_value("main almost full", 32'(k >= NEW_MF_AF), 32'(main_af));
        end
        repeat (4) @(negedge clk);
        check_value("frozen main", 1, 32'(main_af));
        check_value("frozen dest", 3, 32'(dest_empty));
        check_value("error vector", 16, 32'(error_vec));
        check_value("idle", 0, 32'(idle));
        check_value("active", 0, 32'(active));

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/switch_props.sv
`timescale 1ns/100ps
`default_nettype none

module switch_props (
    input wire                                clk,
    input wire                                reset_L,
    input wire                                push_i,
    input wire                                main_pop_i,
    input wire [1:0]                          vc_pop_i,
    input wire                                main_af_i,
    input wire switch_pkg::thresh_t           thresh_i,
    input wire [switch_pkg::NUM_FIFOS-1:0]    empty_i,
    input wire                                idle_i,
    input wire                                active_i,
    input wire                                run_i,
    input wire [switch_pkg::NUM_FIFOS-1:0]    error_i
);

    logic [2:0] occ;
    logic       push_ok;
    logic       pop_ok;

    // main FIFO occupancy rebuilt from its own push and pop
    assign push_ok = push_i && (occ != 3'(switch_pkg::MAIN_DEPTH));
    assign pop_ok = main_pop_i && (occ != 3'd0);

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            occ <= 3'd0;
        end else if (push_ok && !pop_ok) begin
            occ <= occ + 3'd1;
        end else if (pop_ok && !push_ok) begin
            occ <= occ - 3'd1;
        end
    end

    // coming from IDLE or ACTIVE the choice follows the empty flags
    idle_not_active: assert property (
        @(posedge clk) disable iff (!reset_L)
            (idle_i || active_i) |-> (idle_i != active_i)
                && (!$past(run_i) || idle_i == $past(empty_i == switch_pkg::ALL_EMPTY))
    ) else $error("idle and active are wrong for the FIFO empty flags");

    error_held: assert property (
        @(posedge clk) disable iff (!reset_L) (error_i != '0) |=> $stable(error_i)
    ) else $error("captured error vector changed");

    frozen_when_down: assert property (
        @(posedge clk) disable iff (!reset_L)
            !(idle_i || active_i) |-> !main_pop_i && (vc_pop_i == 2'b00)
    ) else $error("router or arbiter moved outside IDLE and ACTIVE");

    main_af_level: assert property (
        @(posedge clk) disable iff (!reset_L)
            main_af_i == (occ >= {1'b0, thresh_i.mf_af})
    ) else $error("main almost-full does not match occupancy");

endmodule

bind switch_top switch_props i_switch_props (
    .clk        (clk),
    .reset_L    (reset_L),
    .push_i     (push_i),
    .main_pop_i (main_pop),
    .vc_pop_i   (vc_pop),
    .main_af_i  (main_af_o),
    .thresh_i   (thresh_o),
    .empty_i    (status.empty),
    .idle_i     (idle_o),
    .active_i   (active_o),
    .run_i      (run),
    .error_i    (error_o)
);

`default_nettype wire

// File: tests/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk_o,
    output logic reset_L_o
);

    initial clk_o = 1'b0;

    always #50 clk_o = ~clk_o;

    // reset low for 8 rising edges, released on a falling edge
    initial begin
        reset_L_o <= 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        reset_L_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: source/switch_top.sv
`timescale 1ns/100ps
`default_nettype none

module switch_top (
    input  wire                                 clk,
    input  wire                                 reset_L,
    input  wire                                 init_i,
    input  wire switch_pkg::thresh_t            thresh_i,
    input  wire                                 push_i,
    input  wire switch_pkg::flit_t              push_data_i,
    input  wire [1:0]                           pop_i,
    output wire switch_pkg::flit_t [1:0]        dest_data_o,
    output wire [1:0]                           dest_empty_o,
    output wire [switch_pkg::NUM_FIFOS-1:0]     error_o,
    output wire                                 idle_o,
    output wire                                 active_o,
    output wire switch_pkg::thresh_t            thresh_o,
    output wire                                 main_af_o,
    output wire                                 main_ae_o
);

    wire switch_pkg::fifo_status_t   status;
    wire                             run;
    wire switch_pkg::flit_t          main_head;
    wire                             main_pop;
    wire                             main_empty;
    wire                             main_err;
    wire switch_pkg::flit_t          vc_in;
    wire switch_pkg::flit_t [1:0]    vc_head;
    wire [1:0]                       vc_push;
    wire [1:0]                       vc_pop;
    wire [1:0]                       vc_empty;
    wire [1:0]                       vc_afull;
    wire [1:0]                       vc_err;
    wire switch_pkg::flit_t          dest_in;
    wire [1:0]                       dest_push;
    wire [1:0]                       dest_afull;
    wire [1:0]                       dest_err;

    assign status.empty = {dest_empty_o, vc_empty, main_empty};
    assign status.error = {dest_err, vc_err, main_err};

    flow_fifo #(.DEPTH(switch_pkg::MAIN_DEPTH)) i_main_fifo (
        .clk            (clk),
        .reset_L        (reset_L),
        .push_i         (push_i),
        .data_i         (push_data_i),
        .pop_i          (main_pop),
        .af_thresh_i    (thresh_o.mf_af),
        .ae_thresh_i    (thresh_o.mf_ae),
        .data_o         (main_head),
        .empty_o        (main_empty),
        .almost_full_o  (main_af_o),
        .almost_empty_o (main_ae_o),
        .error_o        (main_err)
    );

    vc_router i_vc_router (
        .clk          (clk),
        .reset_L      (reset_L),
        .run_i        (run),
        .main_data_i  (main_head),
        .main_empty_i (main_empty),
        .vc_afull_i   (vc_afull),
        .main_pop_o   (main_pop),
        .vc_push_o    (vc_push),
        .vc_data_o    (vc_in)
    );

    for (genvar i = 0; i < 2; i++) begin : g_vc
        flow_fifo #(.DEPTH(switch_pkg::VC_DEPTH)) i_vc_fifo (
            .clk            (clk),
            .reset_L        (reset_L),
            .push_i         (vc_push[i]),
            .data_i         (vc_in),
            .pop_i          (vc_pop[i]),
            .af_thresh_i    (thresh_o.vc_af),
            .ae_thresh_i    (thresh_o.vc_ae),
            .data_o         (vc_head[i]),
            .empty_o        (vc_empty[i]),
            .almost_full_o  (vc_afull[i]),
            .almost_empty_o (),
            .error_o        (vc_err[i])
        );
    end

    dest_arbiter i_dest_arbiter (
        .clk          (clk),
        .reset_L      (reset_L),
        .run_i        (run),
        .vc_data_i    (vc_head),
        .vc_empty_i   (vc_empty),
        .dest_afull_i (dest_afull),
        .vc_pop_o     (vc_pop),
        .dest_push_o  (dest_push),
        .dest_data_o  (dest_in)
    );

    for (genvar i = 0; i < 2; i++) begin : g_dest
        flow_fifo #(.DEPTH(switch_pkg::DEST_DEPTH)) i_dest_fifo (
            .clk            (clk),
            .reset_L        (reset_L),
            .push_i         (dest_push[i]),
            .data_i         (dest_in),
            .pop_i          (pop_i[i]),
            .af_thresh_i    (thresh_o.d_af),
            .ae_thresh_i    (thresh_o.d_ae),
            .data_o         (dest_data_o[i]),
            .empty_o        (dest_empty_o[i]),
            .almost_full_o  (dest_afull[i]),
            .almost_empty_o (),
            .error_o        (dest_err[i])
        );
    end

    link_fsm i_link_fsm (
        .clk      (clk),
        .reset_L  (reset_L),
        .init_i   (init_i),
        .status_i (status),
        .thresh_i (thresh_i),
        .thresh_o (thresh_o),
        .error_o  (error_o),
        .idle_o   (idle_o),
        .active_o (active_o),
        .run_o    (run)
    );

endmodule

`default_nettype wire

// File: source/dest_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module dest_arbiter (
    input  wire                          clk,
    input  wire                          reset_L,
    input  wire                          run_i,
    input  wire switch_pkg::flit_t [1:0] vc_data_i,
    input  wire [1:0]                    vc_empty_i,
    input  wire [1:0]                    dest_afull_i,
    output logic [1:0]                   vc_pop_o,
    output logic [1:0]                   dest_push_o,
    output switch_pkg::flit_t            dest_data_o
);

    logic       ptr;
    logic       sel;
    logic       grant;
    logic [1:0] eligible;

    // skip a channel whose head targets a nearly full destination
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            eligible[i] = run_i && !vc_empty_i[i] && !dest_afull_i[vc_data_i[i].dest];
        end
    end

    assign sel = eligible[ptr] ? ptr : !ptr;
    assign grant = |eligible;
    assign vc_pop_o = grant ? (2'b01 << sel) : 2'b00;

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            ptr <= 1'b0;
            dest_push_o <= 2'b00;
        end else begin
            if (grant) begin
                dest_push_o <= 2'b01 << vc_data_i[sel].dest;
                // other channel goes first next time
                ptr <= !sel;
            end else begin
                dest_push_o <= 2'b00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            dest_data_o <= vc_data_i[sel];
        end
    end

endmodule

`default_nettype wire

// File: source/vc_router.sv
`timescale 1ns/100ps
`default_nettype none

module vc_router (
    input  wire                     clk,
    input  wire                     reset_L,
    input  wire                     run_i,
    input  wire switch_pkg::flit_t  main_data_i,
    input  wire                     main_empty_i,
    input  wire [1:0]               vc_afull_i,
    output logic                    main_pop_o,
    output logic [1:0]              vc_push_o,
    output switch_pkg::flit_t       vc_data_o
);

    // head moves only if its target vc has room
    assign main_pop_o = run_i && !main_empty_i && !vc_afull_i[main_data_i.vc];

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            vc_push_o <= 2'b00;
        end else if (main_pop_o) begin
            vc_push_o <= 2'b01 << main_data_i.vc;
        end else begin
            vc_push_o <= 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (main_pop_o) begin
            vc_data_o <= main_data_i;
        end
    end

endmodule

`default_nettype wire

// File: control/link_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module link_fsm (
    input  wire                                  clk,
    input  wire                                  reset_L,
    input  wire                                  init_i,
    input  wire switch_pkg::fifo_status_t        status_i,
    input  wire switch_pkg::thresh_t             thresh_i,
    output switch_pkg::thresh_t                  thresh_o,
    output logic [switch_pkg::NUM_FIFOS-1:0]     error_o,
    output logic                                 idle_o,
    output logic                                 active_o,
    output logic                                 run_o
);

    switch_pkg::link_state_t state;
    switch_pkg::link_state_t state_next;

    logic [switch_pkg::NUM_FIFOS-1:0] err_cap;
    logic                             fault;

    assign fault = |status_i.error;

    always_comb begin
        state_next = state;
        case (state)
            switch_pkg::RESET: begin
                state_next = switch_pkg::INIT;
            end
            switch_pkg::INIT: begin
                if (!init_i) begin
                    state_next = switch_pkg::IDLE;
                end
            end
            switch_pkg::IDLE, switch_pkg::ACTIVE: begin
                if (fault) begin
                    state_next = switch_pkg::ERROR;
                end else if (init_i) begin
                    state_next = switch_pkg::INIT;
                end else if (status_i.empty == switch_pkg::ALL_EMPTY) begin
                    state_next = switch_pkg::IDLE;
                end else begin
                    state_next = switch_pkg::ACTIVE;
                end
            end
            // only reset leaves ERROR
            switch_pkg::ERROR: begin
                state_next = switch_pkg::ERROR;
            end
            default: begin
                state_next = switch_pkg::RESET;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            state <= switch_pkg::RESET;
            thresh_o <= switch_pkg::THRESH_DEFAULT;
            err_cap <= '0;
        end else begin
            state <= state_next;
            if (state == switch_pkg::INIT) begin
                thresh_o <= thresh_i;
            end
            // captured on the edge into ERROR
            if (run_o && fault) begin
                err_cap <= status_i.error;
            end
        end
    end

    assign idle_o = (state == switch_pkg::IDLE);
    assign active_o = (state == switch_pkg::ACTIVE);
    assign run_o = idle_o || active_o;
    assign error_o = err_cap;

endmodule

`default_nettype wire

// File: source/flow_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module flow_fifo #(
    parameter int DEPTH = 4
) (
    input  wire                       clk,
    input  wire                       reset_L,
    input  wire                       push_i,
    input  wire switch_pkg::flit_t    data_i,
    input  wire                       pop_i,
    input  wire [$clog2(DEPTH)-1:0]   af_thresh_i,
    input  wire [$clog2(DEPTH)-1:0]   ae_thresh_i,
    output switch_pkg::flit_t         data_o,
    output logic                      empty_o,
    output logic                      almost_full_o,
    output logic                      almost_empty_o,
    output logic                      error_o
);

    switch_pkg::flit_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    // msb of count is set only at DEPTH, depth is a power of two
    assign full = count[$clog2(DEPTH)];
    assign empty_o = (count == '0);
    assign almost_full_o = (count >= {1'b0, af_thresh_i});
    assign almost_empty_o = (count <= {1'b0, ae_thresh_i});

    // illegal accesses are dropped
    assign do_push = push_i && !full;
    assign do_pop = pop_i && !empty_o;

    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            error_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // sticky until reset
            if ((push_i && full) || (pop_i && empty_o)) begin
                error_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: common/switch_pkg.sv
`default_nettype none

package switch_pkg;

    // status bit order: main, vc0, vc1, d0, d1
    localparam int NUM_FIFOS = 5;
    localparam logic [NUM_FIFOS-1:0] ALL_EMPTY = 5'b11111;

    localparam int MAIN_DEPTH = 4;
    localparam int VC_DEPTH = 16;
    localparam int DEST_DEPTH = 4;

    localparam logic [1:0] MF_AF_DEFAULT = 2'd2;
    localparam logic [1:0] MF_AE_DEFAULT = 2'd2;
    localparam logic [3:0] VC_AF_DEFAULT = 4'd10;
    localparam logic [3:0] VC_AE_DEFAULT = 4'd3;
    localparam logic [1:0] D_AF_DEFAULT = 2'd2;
    localparam logic [1:0] D_AE_DEFAULT = 2'd2;

    typedef struct packed {
        logic       vc;
        logic       dest;
        logic [3:0] data;
    } flit_t;

    typedef struct packed {
        logic [1:0] mf_af;
        logic [1:0] mf_ae;
        logic [3:0] vc_af;
        logic [3:0] vc_ae;
        logic [1:0] d_af;
        logic [1:0] d_ae;
    } thresh_t;

    typedef struct packed {
        logic [NUM_FIFOS-1:0] empty;
        logic [NUM_FIFOS-1:0] error;
    } fifo_status_t;

    typedef enum logic [4:0] {
        RESET  = 5'b00001,
        INIT   = 5'b00010,
        IDLE   = 5'b00100,
        ACTIVE = 5'b01000,
        ERROR  = 5'b10000
    } link_state_t;

    localparam thresh_t THRESH_DEFAULT = '{
        mf_af: MF_AF_DEFAULT,
        mf_ae: MF_AE_DEFAULT,
        vc_af: VC_AF_DEFAULT,
        vc_ae: VC_AE_DEFAULT,
        d_af:  D_AF_DEFAULT,
        d_ae:  D_AE_DEFAULT
    };

endpackage

`default_nettype wire
